/* compile.f */
+incdir+include
hdl/icache_pkg.sv
hdl/fetch_unit.sv
hdl/icache.sv
hdl/predecode.sv
hdl/fetch_top.sv
tests/mem_model.sv
tests/fetch_tb.sv

/* tests/fetch_tb.sv */
`timescale 1ns/1ps
`include "icache_defs.svh"

module fetch_tb;

    localparam int NUM_RUNS    = 7;
    localparam int NUM_JUMPS   = 4;
    localparam int IMAGE_WORDS = 256;
    localparam int INSTR_CYCLES = 12;   // Worst miss with the longest memory wait
    localparam int DRAIN_CYCLES = 8;

    logic              clk;
    logic              rst;
    logic              start;
    icache_pkg::addr_t start_pc;
    logic              stop;
    logic              flush;
    logic              instr_valid;
    icache_pkg::word_t instr;
    icache_pkg::addr_t instr_pc;
    logic              mem_req_valid;
    icache_pkg::addr_t mem_req_addr;
    logic              mem_resp_valid;
    icache_pkg::word_t mem_resp_data;

    icache_pkg::addr_t run_start [NUM_RUNS];
    int                run_len   [NUM_RUNS];
    bit                run_flush [NUM_RUNS];
    int                run_reqs  [NUM_RUNS];
    icache_pkg::addr_t jump_at   [NUM_JUMPS];
    int                jump_off  [NUM_JUMPS];
    icache_pkg::word_t image     [IMAGE_WORDS];

    icache_pkg::addr_t exp_pc;  // Address of the next instruction due
    int                cur_len;
    int                got;
    int                reqs;
    bit                stop_req;
    int                word_errs;
    int                addr_errs;
    int                count_errs;
    int                other_errs;
    int                cycles;
    int                cycle_limit;

    fetch_top i_fetch_top (.*);
    mem_model i_mem_model (.*);

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    ////////////////////
    // Image and table
    ////////////////////
    function automatic icache_pkg::word_t pattern_word(input icache_pkg::addr_t a);
        return {a[26:2] ^ {a[31:27], 20'h5a3c9}, 7'b0010011};   // OP-IMM opcode never matches JAL
    endfunction

    function automatic icache_pkg::word_t encode_jal(input int off);
        logic [20:0] imm;
        imm = off[20:0];
        return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd1, `OP_JAL};
    endfunction

    function automatic icache_pkg::addr_t next_pc(input icache_pkg::addr_t pc);
        icache_pkg::addr_t target;
        int                j;
        target = pc + 32'd4;
        for (j = 0; j < NUM_JUMPS; j++)
            if (jump_at[j] == pc)
                target = pc + icache_pkg::addr_t'(jump_off[j]);
        return target;
    endfunction

    task automatic add_run(input int idx, input icache_pkg::addr_t a, input int len,
                           input bit fl, input int nreq);
        run_start[idx] = a;
        run_len[idx]   = len;
        run_flush[idx] = fl;
        run_reqs[idx]  = nreq;
    endtask

    task automatic build_image;
        int i;
        for (i = 0; i < IMAGE_WORDS; i++)
            image[i] = pattern_word(icache_pkg::addr_t'(i * 4));
        for (i = 0; i < NUM_JUMPS; i++)
            image[jump_at[i][9:2]] = encode_jal(jump_off[i]);
        for (i = 0; i < IMAGE_WORDS; i++)
            i_mem_model.image[i] = image[i];
    endtask

    ////////////////////
    // Checks
    ////////////////////
    task automatic check_word(input string name, input icache_pkg::word_t got_v,
                              input icache_pkg::word_t exp_v);
        if (got_v !== exp_v)
        begin
            word_errs++;
            $display("[ERROR] %0t %s: got %h, expected %h", $time, name, got_v, exp_v);
        end
    endtask

    task automatic check_addr(input string name, input icache_pkg::addr_t got_v,
                              input icache_pkg::addr_t exp_v);
        if (got_v !== exp_v)
        begin
            addr_errs++;
            $display("[ERROR] %0t %s: got %h, expected %h", $time, name, got_v, exp_v);
        end
    endtask

    task automatic check_count(input string name, input int got_v, input int exp_v);
        if (got_v != exp_v)
        begin
            count_errs++;
            $display("[ERROR] %0t %s: got %0d, expected %0d", $time, name, got_v, exp_v);
        end
    endtask

    // Called once per cycle at the falling edge
    task automatic sample_outputs;
        if (mem_req_valid)
        begin
            reqs++;
            check_addr("mem_req_addr", mem_req_addr, exp_pc);   // Miss is for the pending pc
        end
        if (instr_valid && got >= cur_len)
        begin
            other_errs++;
            $display("An instruction arrived at %0t after fetch should have stopped", $time);
        end
        else if (instr_valid)
        begin
            check_word("instr", instr, image[exp_pc[9:2]]);
            check_addr("instr_pc", instr_pc, exp_pc);
            got++;
            exp_pc = next_pc(exp_pc);
            if (got == cur_len - 1)
                stop_req = 1'b1;   // Lets exactly one more response through
        end
    endtask

    task automatic run_entry(input int e);
        if (run_flush[e])
        begin
            @(posedge clk);
            flush <= 1'b1;
            @(posedge clk);
            flush <= 1'b0;
        end
        exp_pc   = run_start[e];
        cur_len  = run_len[e];
        got      = 0;
        reqs     = 0;
        stop_req = (run_len[e] == 1);
        @(posedge clk);
        start    <= 1'b1;
        start_pc <= run_start[e];
        @(negedge clk);
        sample_outputs();
        while (got < cur_len)
        begin
            @(posedge clk);
            start <= 1'b0;
            stop  <= stop_req;
            stop_req = 1'b0;
            @(negedge clk);
            sample_outputs();
        end
        @(posedge clk);
        stop <= 1'b0;
        repeat (DRAIN_CYCLES)
        begin
            @(negedge clk);
            sample_outputs();
        end
        check_count("mem_req_valid count", reqs, run_reqs[e]);
    endtask

    ////////////////////
    // Main sequence
    ////////////////////
    initial
    begin
        int e;
        int total;
        rst = 1'b1;
        start = 1'b0;
        start_pc = '0;
        stop = 1'b0;
        flush = 1'b0;
        word_errs = 0;
        addr_errs = 0;
        count_errs = 0;
        other_errs = 0;
        jump_at[0] = 32'h0a0;
        jump_off[0] = 32'h060;    // Forward into line 0
        jump_at[1] = 32'h104;
        jump_off[1] = 32'h2f4;    // Far forward to the top of the image
        jump_at[2] = 32'h200;
        jump_off[2] = 32'h040;    // 0x200 and 0x240 share index 0
        jump_at[3] = 32'h240;
        jump_off[3] = -32'sh040;
        add_run(0, 32'h000, 8, 1'b0, 8);   // Cold straight line
        add_run(1, 32'h000, 8, 1'b0, 0);   // Same lines hit throughout
        add_run(2, 32'h098, 7, 1'b0, 7);   // Two jumps and every line new
        add_run(3, 32'h200, 6, 1'b0, 6);   // Ping-pong on one index
        add_run(4, 32'h000, 8, 1'b0, 4);   // Indexes 0, 1, 6, 7 were replaced
        add_run(5, 32'h000, 8, 1'b0, 0);
        add_run(6, 32'h000, 8, 1'b1, 8);   // Flush makes it cold again
        build_image();
        total = 0;
        for (e = 0; e < NUM_RUNS; e++)
            total += run_len[e];
        cycle_limit = total * INSTR_CYCLES + NUM_RUNS * 20 + 50;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        repeat (6)
        begin
            @(negedge clk);
            if (instr_valid || mem_req_valid)
            begin
                other_errs++;
                $display("A strobe went high at %0t before any start", $time);
            end
        end
        for (e = 0; e < NUM_RUNS; e++)
            run_entry(e);
        $display("Errors: %0d (instr %0d, address %0d, count %0d, other %0d)",
                 word_errs + addr_errs + count_errs + other_errs,
                 word_errs, addr_errs, count_errs, other_errs);
        if (word_errs + addr_errs + count_errs + other_errs == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

    initial
    begin
        cycles = 0;
        while (cycle_limit == 0 || cycles < cycle_limit)
        begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout after %0d cycles, the fetch runs did not complete", cycles);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

/* tests/mem_model.sv */
`timescale 1ns/1ps

module mem_model (
    input  logic              clk,
    input  logic              rst,
    input  logic              mem_req_valid,
    input  icache_pkg::addr_t mem_req_addr,
    output logic              mem_resp_valid,
    output icache_pkg::word_t mem_resp_data
);

    localparam int IMAGE_WORDS = 256;
    localparam int MAX_WAIT    = 6;

    icache_pkg::word_t image [IMAGE_WORDS];    // Filled in by the testbench

    integer            seed;
    logic              busy;
    int                wait_cnt;
    icache_pkg::addr_t addr_q;

    initial
        seed = 32'h5b66;

    // One fill outstanding at a time and answered after 1 to MAX_WAIT cycles
    always @(posedge clk)
    begin
        if (rst)
        begin
            busy           <= 1'b0;
            wait_cnt       <= 0;
            mem_resp_valid <= 1'b0;
            mem_resp_data  <= '0;
        end
        else
        begin
            mem_resp_valid <= 1'b0;
            if (mem_req_valid)
            begin
                busy     <= 1'b1;
                addr_q   <= mem_req_addr;
                wait_cnt <= 1 + ($unsigned($random(seed)) % MAX_WAIT);
            end
            else if (busy && wait_cnt <= 1)
            begin
                busy           <= 1'b0;
                mem_resp_valid <= 1'b1;
                mem_resp_data  <= image[addr_q[9:2]];   // 256 words
            end
            else if (busy)
                wait_cnt <= wait_cnt - 1;
        end
    end

endmodule

/* hdl/fetch_top.sv */
`timescale 1ns/1ps

module fetch_top (
    input  logic              clk,
    input  logic              rst,
    input  logic              start,
    input  icache_pkg::addr_t start_pc,
    input  logic              stop,
    input  logic              flush,
    output logic              instr_valid,
    output icache_pkg::word_t instr,
    output icache_pkg::addr_t instr_pc,
    output logic              mem_req_valid,
    output icache_pkg::addr_t mem_req_addr,
    input  logic              mem_resp_valid,
    input  icache_pkg::word_t mem_resp_data
);

    // Fetch to cache
    logic              req_valid;
    icache_pkg::addr_t req_addr;

    // Cache to predecoder and fetch
    logic              resp_valid;
    icache_pkg::word_t resp_data;
    icache_pkg::addr_t resp_addr;

    // Jump redirect back to fetch
    logic              redirect;
    icache_pkg::addr_t redirect_pc;

    fetch_unit i_fetch_unit (
        .clk         (clk),
        .rst         (rst),
        .start       (start),
        .start_pc    (start_pc),
        .stop        (stop),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .resp_valid  (resp_valid),
        .req_valid   (req_valid),
        .req_addr    (req_addr)
    );

    icache i_icache (
        .clk            (clk),
        .rst            (rst),
        .flush          (flush),
        .req_valid      (req_valid),
        .req_addr       (req_addr),
        .resp_valid     (resp_valid),
        .resp_data      (resp_data),
        .resp_addr      (resp_addr),
        .mem_req_valid  (mem_req_valid),
        .mem_req_addr   (mem_req_addr),
        .mem_resp_valid (mem_resp_valid),
        .mem_resp_data  (mem_resp_data)
    );

    predecode i_predecode (
        .clk         (clk),
        .rst         (rst),
        .resp_valid  (resp_valid),
        .resp_data   (resp_data),
        .resp_addr   (resp_addr),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .instr_valid (instr_valid),
        .instr       (instr),
        .instr_pc    (instr_pc)
    );

endmodule

/* hdl/predecode.sv */
`timescale 1ns/1ps
`include "icache_defs.svh"

module predecode (
    input  logic              clk,
    input  logic              rst,
    input  logic              resp_valid,
    input  icache_pkg::word_t resp_data,
    input  icache_pkg::addr_t resp_addr,
    output logic              redirect,
    output icache_pkg::addr_t redirect_pc,
    output logic              instr_valid,
    output icache_pkg::word_t instr,
    output icache_pkg::addr_t instr_pc
);

    localparam int OFF_W = 21;    // JAL immediate including the implied zero

    logic             is_jal;
    logic [OFF_W-1:0] jal_offset;

    ////////////////////
    // JAL decode
    ////////////////////
    assign is_jal = (resp_data[6:0] == `OP_JAL);

    // imm[20|10:1|11|19:12] reordered into a byte offset
    assign jal_offset = {resp_data[31],
                         resp_data[19:12],
                         resp_data[20],
                         resp_data[30:21],
                         1'b0};

    assign redirect    = resp_valid && is_jal;
    assign redirect_pc = resp_addr + {{(`ADDR_W-OFF_W){jal_offset[OFF_W-1]}}, jal_offset};

    ////////////////////
    // Output stage
    ////////////////////
    always_ff @(posedge clk)
    begin
        if (rst)
            instr_valid <= 1'b0;
        else
            instr_valid <= resp_valid;
    end

    always_ff @(posedge clk)
    begin
        if (resp_valid)
        begin
            instr    <= resp_data;
            instr_pc <= resp_addr;
        end
    end

endmodule

/* hdl/icache.sv */
`timescale 1ns/1ps
`include "icache_defs.svh"

module icache (
    input  logic              clk,
    input  logic              rst,
    input  logic              flush,
    input  logic              req_valid,
    input  icache_pkg::addr_t req_addr,
    output logic              resp_valid,
    output icache_pkg::word_t resp_data,
    output icache_pkg::addr_t resp_addr,
    output logic              mem_req_valid,
    output icache_pkg::addr_t mem_req_addr,
    input  logic              mem_resp_valid,
    input  icache_pkg::word_t mem_resp_data
);

    icache_pkg::cache_state_t state;
    icache_pkg::cache_state_t state_next;

    // Valid bit, tag and data for every line
    logic [`LINES-1:0]  valid;
    icache_pkg::tag_t   tag_mem  [`LINES];
    icache_pkg::word_t  data_mem [`LINES];

    icache_pkg::addr_t  addr_q;
    icache_pkg::index_t index;
    icache_pkg::tag_t   tag;
    logic               hit;

    logic               fill_valid;
    icache_pkg::word_t  fill_data;

    assign index = addr_q[`INDEX_MSB:`INDEX_LSB];
    assign tag   = addr_q[`ADDR_W-1:`TAG_LSB];
    assign hit   = valid[index] && (tag_mem[index] == tag);

    ////////////////////
    // Controller
    ////////////////////
    always_comb
    begin
        state_next = state;
        case (state)
            icache_pkg::IDLE:
            begin
                if (req_valid)
                    state_next = icache_pkg::COMPARE;
            end
            icache_pkg::COMPARE:
                state_next = hit ? icache_pkg::RESPOND : icache_pkg::ALLOCATE;
            icache_pkg::ALLOCATE:
            begin
                if (fill_valid)
                    state_next = icache_pkg::RESPOND;
            end
            icache_pkg::RESPOND:
                state_next = icache_pkg::IDLE;
            default:
                state_next = icache_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            state <= icache_pkg::IDLE;
        else
            state <= state_next;
    end

    always_ff @(posedge clk)
    begin
        if (state == icache_pkg::IDLE && req_valid)
            addr_q <= req_addr;
    end

    ////////////////////
    // Miss handling
    ////////////////////
    always_ff @(posedge clk)
    begin
        if (rst)
            mem_req_valid <= 1'b0;
        else
            mem_req_valid <= (state == icache_pkg::COMPARE) && !hit;
    end

    assign mem_req_addr = {addr_q[`ADDR_W-1:`INDEX_LSB], {`INDEX_LSB{1'b0}}};

    // Fill word is staged one cycle before ALLOCATE writes it
    always_ff @(posedge clk)
    begin
        if (rst)
            fill_valid <= 1'b0;
        else
            fill_valid <= mem_resp_valid;
    end

    always_ff @(posedge clk)
    begin
        if (mem_resp_valid)
            fill_data <= mem_resp_data;
    end

    ////////////////////
    // Arrays
    ////////////////////
    always_ff @(posedge clk)
    begin
        if (rst)
            valid <= '0;
        else if (state == icache_pkg::IDLE && flush)
            valid <= '0;                          // Flush drops every line at once
        else if (state == icache_pkg::ALLOCATE && fill_valid)
            valid[index] <= 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (state == icache_pkg::ALLOCATE && fill_valid)
        begin
            tag_mem[index]  <= tag;
            data_mem[index] <= fill_data;
        end
    end

    // Hits and fills both answer from the array
    assign resp_valid = (state == icache_pkg::RESPOND);
    assign resp_data  = data_mem[index];
    assign resp_addr  = addr_q;

endmodule

/* hdl/fetch_unit.sv */
`timescale 1ns/1ps

module fetch_unit (
    input  logic              clk,
    input  logic              rst,
    input  logic              start,
    input  icache_pkg::addr_t start_pc,
    input  logic              stop,
    input  logic              redirect,
    input  icache_pkg::addr_t redirect_pc,
    input  logic              resp_valid,
    output logic              req_valid,
    output icache_pkg::addr_t req_addr
);

    icache_pkg::fetch_state_t state;
    icache_pkg::fetch_state_t state_next;
    icache_pkg::addr_t        pc;
    logic                     stop_pending;
    logic                     stop_seen;

    assign stop_seen = stop_pending | stop;   // Stop in the response cycle counts too

    ////////////////////
    // Sequencer
    ////////////////////
    always_comb
    begin
        state_next = state;
        case (state)
            icache_pkg::STOPPED:
            begin
                if (start)
                    state_next = icache_pkg::ISSUE;
            end
            icache_pkg::ISSUE:
                state_next = icache_pkg::WAIT;
            icache_pkg::WAIT:
            begin
                if (resp_valid)
                    state_next = stop_seen ? icache_pkg::STOPPED : icache_pkg::ISSUE;
            end
            default:
                state_next = icache_pkg::STOPPED;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            state <= icache_pkg::STOPPED;
        else
            state <= state_next;
    end

    // Remember a stop until the outstanding response is back
    always_ff @(posedge clk)
    begin
        if (rst)
            stop_pending <= 1'b0;
        else if (state_next == icache_pkg::STOPPED)
            stop_pending <= 1'b0;
        else if (stop && state != icache_pkg::STOPPED)
            stop_pending <= 1'b1;
    end

    ////////////////////
    // Program counter
    ////////////////////
    always_ff @(posedge clk)
    begin
        if (state == icache_pkg::STOPPED && start)
            pc <= start_pc;
        else if (state == icache_pkg::WAIT && resp_valid)
            pc <= redirect ? redirect_pc : pc + icache_pkg::addr_t'(4);
    end

    assign req_valid = (state == icache_pkg::ISSUE);   // One cycle per request
    assign req_addr  = pc;

endmodule

/* hdl/icache_pkg.sv */
`include "icache_defs.svh"

package icache_pkg;

    typedef logic [`ADDR_W-1:0]              addr_t;
    typedef logic [`WORD_W-1:0]              word_t;
    typedef logic [`INDEX_MSB:`INDEX_LSB]    index_t;
    typedef logic [`ADDR_W-1:`TAG_LSB]       tag_t;

    // Cache controller
    typedef enum logic [1:0] {
        IDLE,
        COMPARE,
        ALLOCATE,
        RESPOND
    } cache_state_t;

    // Fetch sequencer
    typedef enum logic [1:0] {
        STOPPED,
        ISSUE,
        WAIT
    } fetch_state_t;

endpackage

/* include/icache_defs.svh */
`ifndef ICACHE_DEFS_SVH
`define ICACHE_DEFS_SVH

////////////////////
// Datapath widths
////////////////////
`define ADDR_W      32
`define WORD_W      32

////////////////////
// Cache geometry
////////////////////
`define LINES       16
`define INDEX_LSB   2       // Word offset sits below the index
`define INDEX_MSB   5
`define TAG_LSB     6       // Tag is everything above the index

////////////////////
// Opcodes
////////////////////
`define OP_JAL      7'b1101111

`endif
